// ==== isa_pkg.sv ====
// RV32I instruction field types, data word types, opcode and funct3 codes
`default_nettype none

package isa_pkg;

	// A data word, a program counter or a memory address
	typedef logic [31:0] word_t;

	// One raw 32-bit instruction as fetched
	typedef logic [31:0] instr_t;

	// Index into the 32-entry integer register file
	typedef logic [4:0] reg_addr_t;

	// Major opcode, instruction bits 6 to 0
	typedef logic [6:0] opcode_t;

	// Minor function field, instruction bits 14 to 12
	typedef logic [2:0] funct3_t;

	// Major opcodes of the RV32I base set that this path executes
	localparam opcode_t OP_R      = 7'b0110011;
	localparam opcode_t OP_I      = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;

	// Funct3 values shared by the register and immediate arithmetic forms
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	// Logical and arithmetic right shift share one code, bit 30 tells them apart
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// Funct3 values of the conditional branches
	// Codes 010 and 011 are not defined by the ISA
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// ==== alu_pkg.sv ====
// ALU operation codes, operand source codes and pipeline instruction class codes
`default_nettype none

package alu_pkg;

	// Operation selected for the ALU in the execute stage
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;
	// Pass operand b straight through
	localparam alu_op_t ALU_BUF  = 4'd10;
	// Compares, the one-bit answer lands in bit 0 of the result
	localparam alu_op_t ALU_EQ   = 4'd11;
	localparam alu_op_t ALU_GE   = 4'd12;
	localparam alu_op_t ALU_GEU  = 4'd13;
	// Marks an encoding that has no ALU operation
	localparam alu_op_t ALU_BAD  = 4'b1111;

	// Where operand a comes from
	typedef logic [1:0] src_a_t;

	localparam src_a_t SRC_A_RS1  = 2'd0;
	localparam src_a_t SRC_A_PC   = 2'd1;
	localparam src_a_t SRC_A_ZERO = 2'd2;

	// Where operand b comes from
	typedef logic src_b_t;

	localparam src_b_t SRC_B_RS2 = 1'b0;
	localparam src_b_t SRC_B_IMM = 1'b1;

	// Instruction class, tells the result stage how to use the ALU result
	typedef logic [2:0] iclass_t;

	localparam iclass_t CLS_ALU    = 3'd0;
	localparam iclass_t CLS_LOAD   = 3'd1;
	localparam iclass_t CLS_STORE  = 3'd2;
	localparam iclass_t CLS_BRANCH = 3'd3;
	localparam iclass_t CLS_JAL    = 3'd4;
	localparam iclass_t CLS_JALR   = 3'd5;
	localparam iclass_t CLS_NONE   = 3'd6;

endpackage

`default_nettype wire

// ==== instr_decoder.sv ====
// Decode stage that maps an RV32I instruction to ALU controls, immediate and writeback controls
`default_nettype none

module instr_decoder
	import isa_pkg::*, alu_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire logic      i_valid,
	input  wire instr_t    i_instr,
	input  wire word_t     i_pc,
	input  wire word_t     i_rs1,
	input  wire word_t     i_rs2,
	output logic           o_valid,
	output word_t          o_pc,
	output word_t          o_rs1,
	output word_t          o_rs2,
	output word_t          o_imm,
	output alu_op_t        o_alu_op,
	output src_a_t         o_src_a,
	output src_b_t         o_src_b,
	output iclass_t        o_class,
	output reg_addr_t      o_rd,
	output logic           o_rd_we,
	output logic           o_br_inv,
	output logic           o_illegal
);

	// Map funct3 and bit 30 of an arithmetic instruction to an ALU operation
	// Bit 30 is a function bit for the register form and for the immediate shifts only,
	// elsewhere in the immediate form it is part of the immediate
	function automatic alu_op_t arith_op(input funct3_t f3, input logic b30, input logic is_reg);
		alu_op_t op;
		case (f3)
			F3_ADD:  op = (is_reg && b30) ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = b30 ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			F3_AND:  op = ALU_AND;
			default: op = ALU_BAD;
		endcase
		// A set function bit is only meaningful for add and shift right
		if (b30 && (is_reg || f3 == F3_SLL) && f3 != F3_ADD && f3 != F3_SR)
			op = ALU_BAD;
		return op;
	endfunction

	opcode_t   opcode;
	funct3_t   funct3;
	reg_addr_t rd;
	logic      bit30;

	// Immediates of every format, sign extended where the ISA says so
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;

	alu_op_t   alu_op;
	src_a_t    src_a;
	src_b_t    src_b;
	word_t     imm;
	iclass_t   cls;
	logic      known_op;
	logic      writes_rd;
	logic      br_inv;
	logic      illegal;
	logic      rd_we;

	assign opcode = i_instr[6:0];
	assign rd     = i_instr[11:7];
	assign funct3 = i_instr[14:12];
	assign bit30  = i_instr[30];

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	always_comb begin
		// Defaults describe an unknown opcode
		alu_op    = ALU_BAD;
		src_a     = SRC_A_RS1;
		src_b     = SRC_B_IMM;
		imm       = '0;
		cls       = CLS_NONE;
		known_op  = 1'b1;
		writes_rd = 1'b0;
		br_inv    = 1'b0;
		case (opcode)
			OP_R: begin
				src_b     = SRC_B_RS2;
				cls       = CLS_ALU;
				writes_rd = 1'b1;
				alu_op    = arith_op(funct3, bit30, 1'b1);
			end
			OP_I: begin
				imm       = imm_i;
				cls       = CLS_ALU;
				writes_rd = 1'b1;
				alu_op    = arith_op(funct3, bit30, 1'b0);
			end
			OP_LOAD: begin
				// Effective address is rs1 plus the I offset
				imm       = imm_i;
				cls       = CLS_LOAD;
				writes_rd = 1'b1;
				alu_op    = ALU_ADD;
			end
			OP_STORE: begin
				imm       = imm_s;
				cls       = CLS_STORE;
				alu_op    = ALU_ADD;
			end
			OP_BRANCH: begin
				// ALU compares rs1 with rs2, the PC adder forms the target
				src_b = SRC_B_RS2;
				imm   = imm_b;
				cls   = CLS_BRANCH;
				case (funct3)
					F3_BEQ, F3_BNE:   alu_op = ALU_EQ;
					F3_BLT, F3_BGE:   alu_op = ALU_GE;
					F3_BLTU, F3_BGEU: alu_op = ALU_GEU;
					default:          alu_op = ALU_BAD;
				endcase
				// These take the branch when the compare answer is false
				br_inv = (funct3 == F3_BNE) || (funct3 == F3_BLT) || (funct3 == F3_BLTU);
			end
			OP_JAL: begin
				src_a     = SRC_A_ZERO;
				imm       = imm_j;
				cls       = CLS_JAL;
				writes_rd = 1'b1;
				alu_op    = ALU_BUF;
			end
			OP_JALR: begin
				// Target is rs1 plus the I offset, bit 0 is cleared later
				imm       = imm_i;
				cls       = CLS_JALR;
				writes_rd = 1'b1;
				alu_op    = ALU_ADD;
			end
			OP_LUI: begin
				src_a     = SRC_A_ZERO;
				imm       = imm_u;
				cls       = CLS_ALU;
				writes_rd = 1'b1;
				alu_op    = ALU_BUF;
			end
			OP_AUIPC: begin
				src_a     = SRC_A_PC;
				imm       = imm_u;
				cls       = CLS_ALU;
				writes_rd = 1'b1;
				alu_op    = ALU_ADD;
			end
			default: known_op = 1'b0;
		endcase
	end

	assign illegal = !known_op || (alu_op == ALU_BAD);
	// Register zero is hardwired, so a write to it is dropped here
	assign rd_we = writes_rd && !illegal && (rd != 5'd0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid   <= 1'b0;
			o_pc      <= '0;
			o_rs1     <= '0;
			o_rs2     <= '0;
			o_imm     <= '0;
			o_alu_op  <= ALU_ADD;
			o_src_a   <= SRC_A_RS1;
			o_src_b   <= SRC_B_RS2;
			o_class   <= CLS_NONE;
			o_rd      <= '0;
			o_rd_we   <= 1'b0;
			o_br_inv  <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_pc      <= i_pc;
				o_rs1     <= i_rs1;
				o_rs2     <= i_rs2;
				o_imm     <= imm;
				o_alu_op  <= alu_op;
				o_src_a   <= src_a;
				o_src_b   <= src_b;
				o_class   <= illegal ? CLS_NONE : cls;
				o_rd      <= rd;
				o_rd_we   <= rd_we;
				o_br_inv  <= br_inv;
				o_illegal <= illegal;
			end
		end
	end

	// An illegal instruction must never reach the register file
	a_illegal_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_valid && o_illegal) |-> !o_rd_we);

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
// Execute stage with the operand multiplexers, the ALU and the PC adders, registered
`default_nettype none

module alu_execute
	import isa_pkg::*, alu_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire logic      i_valid,
	input  wire word_t     i_pc,
	input  wire word_t     i_rs1,
	input  wire word_t     i_rs2,
	input  wire word_t     i_imm,
	input  wire alu_op_t   i_alu_op,
	input  wire src_a_t    i_src_a,
	input  wire src_b_t    i_src_b,
	input  wire iclass_t   i_class,
	input  wire reg_addr_t i_rd,
	input  wire logic      i_rd_we,
	input  wire logic      i_br_inv,
	input  wire logic      i_illegal,
	output logic           o_valid,
	output word_t          o_alu_res,
	output word_t          o_pc,
	output word_t          o_pc_plus4,
	output word_t          o_pc_plus_imm,
	output iclass_t        o_class,
	output reg_addr_t      o_rd,
	output logic           o_rd_we,
	output logic           o_br_inv,
	output logic           o_illegal
);

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;
	word_t      alu_res;

	always_comb begin
		case (i_src_a)
			SRC_A_PC:   op_a = i_pc;
			SRC_A_ZERO: op_a = '0;
			default:    op_a = i_rs1;
		endcase
	end

	assign op_b  = (i_src_b == SRC_B_IMM) ? i_imm : i_rs2;
	// Shifts use only the low five bits of operand b
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'b0, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> shamt;
			ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_BUF:  alu_res = op_b;
			// Compare answers sit in bit 0 with the upper bits zero
			ALU_EQ:   alu_res = {31'b0, op_a == op_b};
			ALU_GE:   alu_res = {31'b0, $signed(op_a) >= $signed(op_b)};
			ALU_GEU:  alu_res = {31'b0, op_a >= op_b};
			default:  alu_res = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid       <= 1'b0;
			o_alu_res     <= '0;
			o_pc          <= '0;
			o_pc_plus4    <= '0;
			o_pc_plus_imm <= '0;
			o_class       <= CLS_NONE;
			o_rd          <= '0;
			o_rd_we       <= 1'b0;
			o_br_inv      <= 1'b0;
			o_illegal     <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_alu_res     <= alu_res;
				o_pc          <= i_pc;
				// Fall-through address and the branch or JAL target
				o_pc_plus4    <= i_pc + 32'd4;
				o_pc_plus_imm <= i_pc + i_imm;
				o_class       <= i_class;
				o_rd          <= i_rd;
				o_rd_we       <= i_rd_we;
				o_br_inv      <= i_br_inv;
				o_illegal     <= i_illegal;
			end
		end
	end

	// The decoder flags every encoding without an ALU operation as illegal
	a_bad_op_flagged: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_valid && i_alu_op == ALU_BAD) |-> i_illegal);

endmodule

`default_nettype wire

// ==== result_select.sv ====
// Result stage that picks the writeback value, resolves branches and forms the next PC
`default_nettype none

module result_select
	import isa_pkg::*, alu_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire logic      i_valid,
	input  wire word_t     i_alu_res,
	input  wire word_t     i_pc,
	input  wire word_t     i_pc_plus4,
	input  wire word_t     i_pc_plus_imm,
	input  wire iclass_t   i_class,
	input  wire reg_addr_t i_rd,
	input  wire logic      i_rd_we,
	input  wire logic      i_br_inv,
	input  wire logic      i_illegal,
	output logic           o_valid,
	output reg_addr_t      o_rd,
	output logic           o_rd_we,
	output word_t          o_rd_data,
	output word_t          o_mem_addr,
	output logic           o_is_load,
	output logic           o_is_store,
	output logic           o_branch_taken,
	output word_t          o_next_pc,
	output logic           o_illegal
);

	logic  is_jump;
	logic  taken;
	word_t rd_data;
	word_t next_pc;
	word_t mem_addr;

	assign is_jump = (i_class == CLS_JAL) || (i_class == CLS_JALR);

	// Compare answer in bit 0, flipped for the branches that take on a false answer
	assign taken = ((i_class == CLS_BRANCH) && (i_alu_res[0] ^ i_br_inv)) || is_jump;

	// Jumps write the return address, everything else the ALU result
	assign rd_data = is_jump ? i_pc_plus4 : i_alu_res;

	always_comb begin
		if (i_class == CLS_JALR)
			next_pc = {i_alu_res[31:1], 1'b0};
		else if (taken)
			next_pc = i_pc_plus_imm;
		else
			next_pc = i_pc_plus4;
	end

	assign mem_addr = ((i_class == CLS_LOAD) || (i_class == CLS_STORE)) ? i_alu_res : '0;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid        <= 1'b0;
			o_rd           <= '0;
			o_rd_we        <= 1'b0;
			o_rd_data      <= '0;
			o_mem_addr     <= '0;
			o_is_load      <= 1'b0;
			o_is_store     <= 1'b0;
			o_branch_taken <= 1'b0;
			o_next_pc      <= '0;
			o_illegal      <= 1'b0;
		end else begin
			o_valid <= i_valid;
			// Write enable is qualified with valid so it never lingers
			o_rd_we <= i_valid && i_rd_we;
			if (i_valid) begin
				o_rd           <= i_rd;
				o_rd_data      <= rd_data;
				o_mem_addr     <= mem_addr;
				o_is_load      <= (i_class == CLS_LOAD);
				o_is_store     <= (i_class == CLS_STORE);
				o_branch_taken <= taken;
				o_next_pc      <= next_pc;
				o_illegal      <= i_illegal;
			end
		end
	end

	a_load_store_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_is_load && o_is_store));

endmodule

`default_nettype wire

// ==== int_exec_top.sv ====
// Top level of the integer execute path chaining decode, execute and result stages
`default_nettype none

module int_exec_top
	import isa_pkg::*, alu_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire logic      i_valid,
	input  wire instr_t    i_instr,
	input  wire word_t     i_pc,
	input  wire word_t     i_rs1,
	input  wire word_t     i_rs2,
	output logic           o_valid,
	output reg_addr_t      o_rd,
	output logic           o_rd_we,
	output word_t          o_rd_data,
	output word_t          o_mem_addr,
	output logic           o_is_load,
	output logic           o_is_store,
	output logic           o_branch_taken,
	output word_t          o_next_pc,
	output logic           o_illegal
);

	// Decode to execute
	logic      dec_valid;
	word_t     dec_pc, dec_rs1, dec_rs2, dec_imm;
	alu_op_t   dec_alu_op;
	src_a_t    dec_src_a;
	src_b_t    dec_src_b;
	iclass_t   dec_class;
	reg_addr_t dec_rd;
	logic      dec_rd_we, dec_br_inv, dec_illegal;

	// Execute to result
	logic      ex_valid;
	word_t     ex_alu_res, ex_pc, ex_pc_plus4, ex_pc_plus_imm;
	iclass_t   ex_class;
	reg_addr_t ex_rd;
	logic      ex_rd_we, ex_br_inv, ex_illegal;

	instr_decoder u_decode (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_valid(i_valid), .i_instr(i_instr),
		.i_pc(i_pc), .i_rs1(i_rs1), .i_rs2(i_rs2),
		.o_valid(dec_valid), .o_pc(dec_pc), .o_rs1(dec_rs1), .o_rs2(dec_rs2),
		.o_imm(dec_imm), .o_alu_op(dec_alu_op), .o_src_a(dec_src_a), .o_src_b(dec_src_b),
		.o_class(dec_class), .o_rd(dec_rd), .o_rd_we(dec_rd_we), .o_br_inv(dec_br_inv),
		.o_illegal(dec_illegal)
	);

	alu_execute u_execute (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_valid(dec_valid), .i_pc(dec_pc),
		.i_rs1(dec_rs1), .i_rs2(dec_rs2), .i_imm(dec_imm), .i_alu_op(dec_alu_op),
		.i_src_a(dec_src_a), .i_src_b(dec_src_b), .i_class(dec_class), .i_rd(dec_rd),
		.i_rd_we(dec_rd_we), .i_br_inv(dec_br_inv), .i_illegal(dec_illegal),
		.o_valid(ex_valid), .o_alu_res(ex_alu_res), .o_pc(ex_pc), .o_pc_plus4(ex_pc_plus4),
		.o_pc_plus_imm(ex_pc_plus_imm), .o_class(ex_class), .o_rd(ex_rd),
		.o_rd_we(ex_rd_we), .o_br_inv(ex_br_inv), .o_illegal(ex_illegal)
	);

	result_select u_result (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_valid(ex_valid), .i_alu_res(ex_alu_res),
		.i_pc(ex_pc), .i_pc_plus4(ex_pc_plus4), .i_pc_plus_imm(ex_pc_plus_imm),
		.i_class(ex_class), .i_rd(ex_rd), .i_rd_we(ex_rd_we), .i_br_inv(ex_br_inv),
		.i_illegal(ex_illegal),
		.o_valid(o_valid), .o_rd(o_rd), .o_rd_we(o_rd_we), .o_rd_data(o_rd_data),
		.o_mem_addr(o_mem_addr), .o_is_load(o_is_load), .o_is_store(o_is_store),
		.o_branch_taken(o_branch_taken), .o_next_pc(o_next_pc), .o_illegal(o_illegal)
	);

endmodule

`default_nettype wire

// ==== tb_int_exec.sv ====
// Testbench for the integer execute path that replays file vectors with random gaps
`default_nettype none

module tb_int_exec
	import isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_VEC     = 64;
	localparam int DRAIN_LIMIT = 50;

	logic      clk;
	logic      arst_n;
	logic      valid;
	instr_t    instr;
	word_t     pc;
	word_t     rs1;
	word_t     rs2;

	logic      out_valid;
	reg_addr_t rd;
	logic      rd_we;
	word_t     rd_data;
	word_t     mem_addr;
	logic      is_load;
	logic      is_store;
	logic      branch_taken;
	word_t     next_pc;
	logic      illegal;

	// Vector storage, inputs first and then the expected outputs
	instr_t    vec_instr [MAX_VEC];
	word_t     vec_pc [MAX_VEC];
	word_t     vec_rs1 [MAX_VEC];
	word_t     vec_rs2 [MAX_VEC];
	logic      exp_rd_we [MAX_VEC];
	reg_addr_t exp_rd [MAX_VEC];
	word_t     exp_rd_data [MAX_VEC];
	word_t     exp_mem_addr [MAX_VEC];
	logic      exp_is_load [MAX_VEC];
	logic      exp_is_store [MAX_VEC];
	logic      exp_taken [MAX_VEC];
	word_t     exp_next_pc [MAX_VEC];
	logic      exp_illegal [MAX_VEC];

	int num_vec;
	int issue_idx;
	int seed;
	int value_errors;
	int protocol_errors;
	int results_checked;
	int pop_idx;

	// Indices of issued vectors whose results are still in the pipeline
	int pending [$];

	int_exec_top u_int_exec_top (
		.i_clk(clk), .i_arst_n(arst_n), .i_valid(valid), .i_instr(instr),
		.i_pc(pc), .i_rs1(rs1), .i_rs2(rs2),
		.o_valid(out_valid), .o_rd(rd), .o_rd_we(rd_we), .o_rd_data(rd_data),
		.o_mem_addr(mem_addr), .o_is_load(is_load), .o_is_store(is_store),
		.o_branch_taken(branch_taken), .o_next_pc(next_pc), .o_illegal(illegal)
	);

	always #2 clk = ~clk;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic load_vectors();
		int        fd;
		int        n;
		string     line;
		instr_t    t_instr;
		word_t     t_pc;
		word_t     t_rs1;
		word_t     t_rs2;
		word_t     t_rd_data;
		word_t     t_mem_addr;
		word_t     t_next_pc;
		reg_addr_t t_rd;
		logic      t_rd_we;
		logic      t_is_load;
		logic      t_is_store;
		logic      t_taken;
		logic      t_illegal;
		num_vec = 0;
		fd = $fopen("int_exec_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file int_exec_stim.txt");
			protocol_errors++;
			return;
		end
		while (!$feof(fd) && num_vec < MAX_VEC) begin
			line = "";
			n = $fgets(line, fd);
			// Comment and blank lines carry no vector
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				t_instr, t_pc, t_rs1, t_rs2, t_rd_we, t_rd, t_rd_data, t_mem_addr,
				t_is_load, t_is_store, t_taken, t_next_pc, t_illegal);
			if (n != 13) begin
				$display("Stimulus line could not be parsed: %s", line);
				protocol_errors++;
			end else begin
				vec_instr[num_vec]    = t_instr;
				vec_pc[num_vec]       = t_pc;
				vec_rs1[num_vec]      = t_rs1;
				vec_rs2[num_vec]      = t_rs2;
				exp_rd_we[num_vec]    = t_rd_we;
				exp_rd[num_vec]       = t_rd;
				exp_rd_data[num_vec]  = t_rd_data;
				exp_mem_addr[num_vec] = t_mem_addr;
				exp_is_load[num_vec]  = t_is_load;
				exp_is_store[num_vec] = t_is_store;
				exp_taken[num_vec]    = t_taken;
				exp_next_pc[num_vec]  = t_next_pc;
				exp_illegal[num_vec]  = t_illegal;
				num_vec++;
			end
		end
		$fclose(fd);
	endtask

	task automatic compare_result(input int i);
		check_flag("o_rd_we", rd_we, exp_rd_we[i]);
		// Destination and data only matter when the register file is written
		if (exp_rd_we[i]) begin
			check_reg("o_rd", rd, exp_rd[i]);
			check_word("o_rd_data", rd_data, exp_rd_data[i]);
		end
		check_word("o_mem_addr", mem_addr, exp_mem_addr[i]);
		check_flag("o_is_load", is_load, exp_is_load[i]);
		check_flag("o_is_store", is_store, exp_is_store[i]);
		check_flag("o_branch_taken", branch_taken, exp_taken[i]);
		check_word("o_next_pc", next_pc, exp_next_pc[i]);
		check_flag("o_illegal", illegal, exp_illegal[i]);
		results_checked++;
	endtask

	// Inputs are sampled on the same edge as the DUT, so issue and result order match
	always @(posedge clk) begin
		if (arst_n && valid)
			pending.push_back(issue_idx);
		if (rd_we && !out_valid) begin
			$display("Write enable is high without o_valid at %0t", $time);
			protocol_errors++;
		end
		if (out_valid) begin
			if (pending.size() == 0) begin
				$display("Unexpected result at %0t, no instruction is outstanding", $time);
				protocol_errors++;
			end else begin
				pop_idx = pending.pop_front();
				compare_result(pop_idx);
			end
		end
	end

	initial begin
		int gap;
		int cycles;
		clk             = 1'b0;
		arst_n          = 1'b0;
		valid           = 1'b0;
		instr           = '0;
		pc              = '0;
		rs1             = '0;
		rs2             = '0;
		issue_idx       = 0;
		seed            = 32'ha2f9c240;
		value_errors    = 0;
		protocol_errors = 0;
		results_checked = 0;
		load_vectors();
		if (num_vec == 0) begin
			$display("No vectors were read from the stimulus file");
			protocol_errors++;
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		for (int k = 0; k < num_vec; k++) begin
			// Zero to two idle cycles, zero gives back-to-back issue
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) begin
				@(posedge clk);
				valid <= 1'b0;
			end
			@(posedge clk);
			valid     <= 1'b1;
			instr     <= vec_instr[k];
			pc        <= vec_pc[k];
			rs1       <= vec_rs1[k];
			rs2       <= vec_rs2[k];
			issue_idx <= k;
		end
		@(posedge clk);
		valid <= 1'b0;
		// Queue changes on rising edges, so it is read on falling ones
		cycles = 0;
		@(negedge clk);
		while (pending.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (pending.size() != 0) begin
			$display("Timed out with %0d results missing", pending.size());
			protocol_errors++;
		end
		// A few more cycles catch any extra o_valid
		repeat (4) @(negedge clk);
		$display("Checked %0d of %0d results: %0d value errors, %0d protocol errors",
			results_checked, num_vec, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== int_exec_stim.txt ====
# Columns: instr pc rs1 rs2, then expected rd_we rd rd_data mem_addr is_load is_store taken next_pc illegal
# All fields hexadecimal, one vector per line
# R type add, sub, shifts, compares and logic with rd x3
002081B3 00001000 00000005 00000007 1 03 0000000C 00000000 0 0 0 00001004 0
402081B3 00001004 00000005 00000007 1 03 FFFFFFFE 00000000 0 0 0 00001008 0
002091B3 00001008 00000003 00000024 1 03 00000030 00000000 0 0 0 0000100C 0
0020D1B3 0000100C 80000000 0000001F 1 03 00000001 00000000 0 0 0 00001010 0
4020D1B3 00001010 F0000000 00000024 1 03 FF000000 00000000 0 0 0 00001014 0
0020A1B3 00001014 FFFFFFFF 00000001 1 03 00000001 00000000 0 0 0 00001018 0
0020B1B3 00001018 FFFFFFFF 00000001 1 03 00000000 00000000 0 0 0 0000101C 0
0020C1B3 0000101C F0F0F0F0 FF00FF00 1 03 0FF00FF0 00000000 0 0 0 00001020 0
0020E1B3 00001020 F0F0F0F0 FF00FF00 1 03 FFF0FFF0 00000000 0 0 0 00001024 0
0020F1B3 00001024 F0F0F0F0 FF00FF00 1 03 F000F000 00000000 0 0 0 00001028 0
# I type addi, srai and slli with rd x5
FFD08293 00001028 00000010 00000000 1 05 0000000D 00000000 0 0 0 0000102C 0
4080D293 0000102C 80000000 00000000 1 05 FF800000 00000000 0 0 0 00001030 0
01F09293 00001030 00000003 00000000 1 05 80000000 00000000 0 0 0 00001034 0
# Branches taken and not taken, offset +16 except the first at -8
FE208CE3 00002000 00001234 00001234 0 19 00000001 00000000 0 0 1 00001FF8 0
00208863 00002004 00000001 00000002 0 10 00000000 00000000 0 0 0 00002008 0
00209863 00002008 00000001 00000002 0 10 00000000 00000000 0 0 1 00002018 0
00209863 0000200C 00000007 00000007 0 10 00000001 00000000 0 0 0 00002010 0
0020C863 00002010 FFFFFFFF 00000001 0 10 00000000 00000000 0 0 1 00002020 0
0020C863 00002014 00000005 FFFFFFFF 0 10 00000001 00000000 0 0 0 00002018 0
0020D863 00002018 00000005 00000005 0 10 00000001 00000000 0 0 1 00002028 0
0020D863 0000201C 80000000 00000000 0 10 00000000 00000000 0 0 0 00002020 0
0020E863 00002020 00000001 FFFFFFFF 0 10 00000000 00000000 0 0 1 00002030 0
0020E863 00002024 FFFFFFFF 00000001 0 10 00000001 00000000 0 0 0 00002028 0
0020F863 00002028 FFFFFFFF 00000001 0 10 00000001 00000000 0 0 1 00002038 0
0020F863 0000202C 00000001 FFFFFFFF 0 10 00000000 00000000 0 0 0 00002030 0
# Jumps, upper immediates, load, store and a write to x0
100000EF 00003000 00000000 00000000 1 01 00003004 00000000 0 0 1 00003100 0
005300E7 00003004 00004000 00000000 1 01 00003008 00000000 0 0 1 00004004 0
ABCDE3B7 00003008 00000000 00000000 1 07 ABCDE000 00000000 0 0 0 0000300C 0
00012417 0000300C 00000000 00000000 1 08 0001500C 00000000 0 0 0 00003010 0
FFC52483 00003010 00008000 00000000 1 09 00007FFC 00007FFC 1 0 0 00003014 0
00B52A23 00003014 00008000 12345678 0 14 00008014 00008014 0 1 0 00003018 0
00508013 00003018 00000001 00000000 0 00 00000006 00000000 0 0 0 0000301C 0
# Illegal: unknown opcode, branch funct3 010, xor with bit 30, ecall
00000F8B 00004000 00000001 00000002 0 1F 00000000 00000000 0 0 0 00004004 1
0020A863 00004004 00000000 00000000 0 10 00000000 00000000 0 0 0 00004008 1
4020C1B3 00004008 00000001 00000002 0 03 00000000 00000000 0 0 0 0000400C 1
00000073 0000400C 00000000 00000000 0 00 00000000 00000000 0 0 0 00004010 1

// ==== compile.f ====
isa_pkg.sv
alu_pkg.sv
instr_decoder.sv
alu_execute.sv
result_select.sv
int_exec_top.sv
tb_int_exec.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_int_exec -f compile.f -o tb_int_exec
	./obj_dir/tb_int_exec | tee $(LOG)
	@grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
